/* verilog.f */
+incdir+include
design/memStagePkg.sv
design/mainMemory.sv
design/memWbReg.sv
design/l1Cache.sv
design/l2Cache.sv
design/memStage.sv
tests/memStageChecks.sv
tests/memStageTb.sv

/* Bender.yml */
package:
  name: mem_stage

sources:
  - include_dirs:
      - include
    files:
      - design/memStagePkg.sv
      - design/mainMemory.sv
      - design/memWbReg.sv
      - design/l1Cache.sv
      - design/l2Cache.sv
      - design/memStage.sv
  - target: test
    files:
      - tests/memStageChecks.sv
      - tests/memStageTb.sv

/* tests/memStageTb.sv */
`timescale 1ns/1ps

module memStageTb;
    import memStagePkg::*;

    localparam int timeoutCycles = 200;

    logic        clk;
    logic        rstN;
    logic        regWriteM;
    resultSrcT   resultSrcM;
    logic        memWriteM;
    logic [31:0] aluOutM;
    logic [31:0] rd2M;
    logic [2:0]  funct3M;
    logic [4:0]  rdM;
    logic [31:0] incPcM;
    logic        regWriteW;
    resultSrcT   resultSrcW;
    logic [31:0] aluOutW;
    logic [31:0] readDataW;
    logic [4:0]  rdW;
    logic [31:0] incPcW;
    logic        stall;

    // expected values handed to the checker.
    logic [31:0] expData;
    logic        loadCheck;
    logic        expectHit;
    logic        expectMiss;
    logic        checkFailed;

    // byte image of main memory, little endian.
    logic [7:0]  model [4096];
    int          seed;

    memStage uut (.*);

    memStageChecks checks (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge checkFailed) begin
        $display("ERRORS FOUND");
        $fatal(1, "a check on the stage outputs failed");
    end

    // tags 0..31 are for random traffic, higher tags are kept for directed cases.
    function automatic logic [31:0] setAddr(input int setSel, input int tagSel);
        setAddr = {20'b0, 6'(tagSel), 2'b00, 2'(setSel), 2'b00};
    endfunction

    function automatic logic [31:0] expectedLoad(input logic [2:0] f3, input logic [31:0] a);
        logic [11:0] base;
        logic [7:0]  b;
        logic [15:0] h;
        base = a[11:0];
        b    = model[base];
        h    = {model[base + 12'd1], model[base]};
        case (accessSizeT'(f3[1:0]))
            sizeByte: expectedLoad = f3[2] ? {24'b0, b} : {{24{b[7]}}, b};
            sizeHalf: expectedLoad = f3[2] ? {16'b0, h} : {{16{h[15]}}, h};
            default:  expectedLoad = {model[base + 12'd3], model[base + 12'd2], h};
        endcase
    endfunction

    task automatic updateModel(input logic [2:0] f3, input logic [31:0] a, input logic [31:0] d);
        logic [11:0] base;
        base = a[11:0];
        model[base] = d[7:0];
        if (f3[1:0] != 2'b00) begin
            model[base + 12'd1] = d[15:8];
        end
        if (f3[1:0] == 2'b10) begin
            model[base + 12'd2] = d[23:16];
            model[base + 12'd3] = d[31:24];
        end
    endtask

    task automatic idleCycle();
        @(posedge clk);
        regWriteM <= 1'($random(seed));
        if ($random(seed) & 1) begin
            resultSrcM <= pcPlus4;
        end else begin
            resultSrcM <= aluResult;
        end
        memWriteM  <= 1'b0;
        aluOutM    <= $random(seed);
        rd2M       <= $random(seed);
        rdM        <= 5'($random(seed));
        incPcM     <= $random(seed);
        loadCheck  <= 1'b0;
        expectHit  <= 1'b0;
        expectMiss <= 1'b0;
        @(negedge clk);
    endtask

    ////////////////////////////////////////
    // one load or store, held until done
    ////////////////////////////////////////

    task automatic runAccess(input logic isStore, input logic [2:0] f3, input logic [31:0] a,
                             input logic [31:0] d, input logic hitExpected,
                             input logic missExpected);
        int waited;
        waited = 0;
        @(posedge clk);
        if (isStore) begin
            resultSrcM <= aluResult;
            expData    <= 32'b0;
        end else begin
            resultSrcM <= memResult;
            expData    <= expectedLoad(f3, a);
        end
        regWriteM  <= !isStore;
        memWriteM  <= isStore;
        aluOutM    <= a;
        rd2M       <= d;
        funct3M    <= f3;
        rdM        <= 5'($random(seed));
        incPcM     <= $random(seed);
        loadCheck  <= !isStore;
        expectHit  <= hitExpected;
        expectMiss <= missExpected;
        @(negedge clk);
        // the miss only shows in the cycle the access first appears.
        expectMiss <= 1'b0;
        while (stall) begin
            if (waited >= timeoutCycles) begin
                $display("Timeout: the stage never finished the access to address %h", a);
                $display("ERRORS FOUND");
                $fatal(1, "stall stayed high");
            end
            waited++;
            @(negedge clk);
        end
        if (isStore) begin
            updateModel(f3, a, d);
        end
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] chain [6];
        logic [2:0]  f3;
        int          kind;
        int          sz;
        seed       = 13;
        rstN       = 1'b0;
        regWriteM  = 1'b0;
        resultSrcM = aluResult;
        memWriteM  = 1'b0;
        aluOutM    = 32'b0;
        rd2M       = 32'b0;
        funct3M    = 3'b010;
        rdM        = 5'b0;
        incPcM     = 32'b0;
        expData    = 32'b0;
        loadCheck  = 1'b0;
        expectHit  = 1'b0;
        expectMiss = 1'b0;
        for (int k = 0; k < 4096; k++) begin
            model[k] = 8'h00;
        end
        repeat (16) @(posedge clk);
        rstN <= 1'b1;
        repeat (4) @(posedge clk);

        // word round trips, the load right after the store hits.
        for (int n = 0; n < 6; n++) begin
            a = setAddr($random(seed), $random(seed) & 31);
            d = $random(seed);
            runAccess(1'b1, 3'b010, a, d, 1'b0, 1'b0);
            runAccess(1'b0, 3'b010, a, 32'b0, 1'b1, 1'b0);
        end

        // byte and half lanes, with both signs stored.
        a = setAddr(2, 40);
        for (int off = 0; off < 4; off++) begin
            runAccess(1'b1, 3'b000, a + off, {24'b0, off[0], 7'($random(seed))}, 1'b0, 1'b0);
        end
        for (int off = 0; off < 4; off++) begin
            runAccess(1'b0, 3'b000, a + off, 32'b0, 1'b0, 1'b0);
            runAccess(1'b0, 3'b100, a + off, 32'b0, 1'b0, 1'b0);
        end
        for (int off = 0; off < 4; off += 2) begin
            runAccess(1'b1, 3'b001, a + off, {16'b0, off[1], 15'($random(seed))}, 1'b0, 1'b0);
            runAccess(1'b0, 3'b001, a + off, 32'b0, 1'b0, 1'b0);
            runAccess(1'b0, 3'b101, a + off, 32'b0, 1'b0, 1'b0);
        end

        // a cold load misses, the repeat must hit.
        a = setAddr(3, 48);
        runAccess(1'b0, 3'b010, a, 32'b0, 1'b0, 1'b1);
        runAccess(1'b0, 3'b010, a, 32'b0, 1'b1, 1'b0);

        // six lines in one L1 set and one L2 set force dirty evictions down to memory.
        for (int n = 0; n < 6; n++) begin
            chain[n] = setAddr(1, 32 + n);
            runAccess(1'b1, 3'b010, chain[n], $random(seed), 1'b0, 1'b0);
        end
        for (int n = 0; n < 6; n++) begin
            runAccess(1'b0, 3'b010, chain[n], 32'b0, 1'b0, 1'b0);
        end

        // mixed traffic.
        for (int n = 0; n < 60; n++) begin
            kind = $unsigned($random(seed)) % 3;
            sz   = $unsigned($random(seed)) % 3;
            a    = setAddr($random(seed), $random(seed) & 31);
            if (sz == 0) begin
                a = a + ($unsigned($random(seed)) % 4);
            end else if (sz == 1) begin
                a = a + 2 * ($unsigned($random(seed)) % 2);
            end
            f3 = {(sz != 2) && 1'($random(seed)), 2'(sz)};
            if (kind == 0) begin
                idleCycle();
            end else if (kind == 1) begin
                runAccess(1'b1, {1'b0, f3[1:0]}, a, $random(seed), 1'b0, 1'b0);
            end else begin
                runAccess(1'b0, f3, a, 32'b0, 1'b0, 1'b0);
            end
        end

        repeat (3) idleCycle();
        if (checkFailed) begin
            $display("ERRORS FOUND");
            $fatal(1, "a check on the stage outputs failed");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

/* tests/memStageChecks.sv */
`timescale 1ns/1ps

module memStageChecks (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   regWriteM,
    input  memStagePkg::resultSrcT resultSrcM,
    input  logic                   memWriteM,
    input  logic [31:0]            aluOutM,
    input  logic [4:0]             rdM,
    input  logic [31:0]            incPcM,
    input  logic                   regWriteW,
    input  memStagePkg::resultSrcT resultSrcW,
    input  logic [31:0]            aluOutW,
    input  logic [31:0]            readDataW,
    input  logic [4:0]             rdW,
    input  logic [31:0]            incPcW,
    input  logic                   stall,
    input  logic [31:0]            expData,
    input  logic                   loadCheck,
    input  logic                   expectHit,
    input  logic                   expectMiss,
    output logic                   checkFailed
);
    import memStagePkg::*;

    // M side as it stood just before the last rising edge.
    logic        lastActive;
    logic        lastStall;
    logic        lastRegWrite;
    resultSrcT   lastResultSrc;
    logic [31:0] lastAluOut;
    logic [4:0]  lastRd;
    logic [31:0] lastIncPc;
    logic        lastLoad;
    logic [31:0] lastExp;

    initial checkFailed = 1'b0;

    task automatic checkEq(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("Fail %s expected %h actual %h", name, expected, actual);
            checkFailed = 1'b1;
        end
    endtask

    always @(posedge clk) begin
        lastActive    <= rstN;
        lastStall     <= stall;
        lastRegWrite  <= regWriteM;
        lastResultSrc <= resultSrcM;
        lastAluOut    <= aluOutM;
        lastRd        <= rdM;
        lastIncPc     <= incPcM;
        lastLoad      <= loadCheck && !stall;
        lastExp       <= expData;
    end

    ////////////////////////////////////////
    // sampled mid cycle, away from the edge
    ////////////////////////////////////////

    always @(negedge clk) begin
        if (!rstN) begin
            checkEq("regWriteW", 32'd0, regWriteW);
            checkEq("stall", 32'd0, stall);
        end else begin
            // no load and no store, so nothing may stall.
            if (!(resultSrcM == memResult || memWriteM)) begin
                checkEq("stall", 32'd0, stall);
            end
            if (expectHit) begin
                checkEq("stall", 32'd0, stall);
            end
            if (expectMiss) begin
                checkEq("stall", 32'd1, stall);
            end
            if (lastActive && lastStall) begin
                checkEq("regWriteW", 32'd0, regWriteW);
            end
            if (lastActive && !lastStall) begin
                checkEq("regWriteW", lastRegWrite, regWriteW);
                checkEq("resultSrcW", lastResultSrc, resultSrcW);
                checkEq("rdW", lastRd, rdW);
                checkEq("aluOutW", lastAluOut, aluOutW);
                checkEq("incPcW", lastIncPc, incPcW);
            end
            if (lastActive && lastLoad) begin
                checkEq("readDataW", lastExp, readDataW);
            end
        end
    end

endmodule

/* design/memStage.sv */
`timescale 1ns/1ps

module memStage (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   regWriteM,
    input  memStagePkg::resultSrcT resultSrcM,
    input  logic                   memWriteM,
    input  logic [31:0]            aluOutM,
    input  logic [31:0]            rd2M,
    input  logic [2:0]             funct3M,
    input  logic [4:0]             rdM,
    input  logic [31:0]            incPcM,
    output logic                   regWriteW,
    output memStagePkg::resultSrcT resultSrcW,
    output logic [31:0]            aluOutW,
    output logic [31:0]            readDataW,
    output logic [4:0]             rdW,
    output logic [31:0]            incPcW,
    output logic                   stall
);

    logic [31:0] readDataM;

    ////////////////////////////////////////
    // L1 to L2 handshake
    ////////////////////////////////////////
    logic        l2Req;
    logic        l2Ack;
    logic        l2Write;
    logic [31:0] l2Addr;
    logic [31:0] l2WData;
    logic [31:0] l2RData;

    ////////////////////////////////////////
    // L2 to memory handshake
    ////////////////////////////////////////
    logic        memReq;
    logic        memAck;
    logic        memWrite;
    logic [31:0] memAddr;
    logic [31:0] memWData;
    logic [31:0] memRData;

    l1Cache l1 (
        .clk       (clk),
        .rstN      (rstN),
        .resultSrc (resultSrcM),
        .memWrite  (memWriteM),
        .addr      (aluOutM),
        .wData     (rd2M),
        .funct3    (funct3M),
        .readData  (readDataM),
        .stall     (stall),
        .l2Req     (l2Req),
        .l2Write   (l2Write),
        .l2Addr    (l2Addr),
        .l2WData   (l2WData),
        .l2Ack     (l2Ack),
        .l2RData   (l2RData)
    );

    l2Cache l2 (
        .clk      (clk),
        .rstN     (rstN),
        .req      (l2Req),
        .write    (l2Write),
        .addr     (l2Addr),
        .wData    (l2WData),
        .ack      (l2Ack),
        .rData    (l2RData),
        .memReq   (memReq),
        .memWrite (memWrite),
        .memAddr  (memAddr),
        .memWData (memWData),
        .memAck   (memAck),
        .memRData (memRData)
    );

    mainMemory mem (
        .clk   (clk),
        .rstN  (rstN),
        .req   (memReq),
        .write (memWrite),
        .addr  (memAddr),
        .wData (memWData),
        .ack   (memAck),
        .rData (memRData)
    );

    memWbReg mwReg (
        .clk        (clk),
        .rstN       (rstN),
        .stall      (stall),
        .regWriteM  (regWriteM),
        .resultSrcM (resultSrcM),
        .aluOutM    (aluOutM),
        .readDataM  (readDataM),
        .rdM        (rdM),
        .incPcM     (incPcM),
        .regWriteW  (regWriteW),
        .resultSrcW (resultSrcW),
        .aluOutW    (aluOutW),
        .readDataW  (readDataW),
        .rdW        (rdW),
        .incPcW     (incPcW)
    );

endmodule

/* design/l2Cache.sv */
`timescale 1ns/1ps
`include "memstage_params.svh"

module l2Cache (
    input  logic        clk,
    input  logic        rstN,
    input  logic        req,
    input  logic        write,
    input  logic [31:0] addr,
    input  logic [31:0] wData,
    output logic        ack,
    output logic [31:0] rData,
    output logic        memReq,
    output logic        memWrite,
    output logic [31:0] memAddr,
    output logic [31:0] memWData,
    input  logic        memAck,
    input  logic [31:0] memRData
);
    import memStagePkg::*;

    localparam logic [2:0] sIdle      = 3'd0;
    localparam logic [2:0] sWriteback = 3'd1;
    localparam logic [2:0] sFill      = 3'd2;
    localparam logic [2:0] sMemDrop   = 3'd3;
    localparam logic [2:0] sAck       = 3'd4;

    memAddrU             addrU;
    logic [l2IndexW-1:0] idx;
    logic [l2TagW-1:0]   tag;

    logic [l2TagW-1:0] tagArr  [2][`L2_SETS];
    logic [31:0]       dataArr [2][`L2_SETS];
    logic [1:0]        validBits [`L2_SETS];
    logic [1:0]        dirtyBits [`L2_SETS];
    logic [`L2_SETS-1:0] lru;

    logic [1:0] wayHit;
    logic       hit;
    logic       hitWay;
    logic       victim;
    logic       victimDirty;
    logic       tgtWay;
    logic       storeNow;
    logic [2:0] state;

    assign addrU.word = addr;
    assign idx        = addrU.l2View.index;
    assign tag        = addrU.l2View.tag;

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            wayHit[w] = validBits[idx][w] && (tagArr[w][idx] == tag);
        end
    end

    assign hit         = |wayHit;
    assign hitWay      = wayHit[1];
    assign victim      = !validBits[idx][0] ? 1'b0 :
                         !validBits[idx][1] ? 1'b1 : lru[idx];
    assign victimDirty = validBits[idx][victim] && dirtyBits[idx][victim];
    assign tgtWay      = hit ? hitWay : victim;

    // whole words from L1 land without a fetch once the victim is clean.
    assign storeNow = (state == sIdle) && req && write && (hit || !victimDirty);

    assign ack      = (state == sAck);
    assign memReq   = (state == sWriteback) || (state == sFill);
    assign memWrite = (state == sWriteback);
    assign memAddr  = memWrite ? {tagArr[victim][idx], idx, 2'b00} : {addr[31:2], 2'b00};
    assign memWData = dataArr[victim][idx];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= sIdle;
            lru   <= '0;
            for (int s = 0; s < `L2_SETS; s++) begin
                validBits[s] <= 2'b00;
                dirtyBits[s] <= 2'b00;
            end
        end else begin
            case (state)
                sIdle: begin
                    if (storeNow) begin
                        validBits[idx][tgtWay] <= 1'b1;
                        dirtyBits[idx][tgtWay] <= 1'b1;
                        lru[idx]               <= ~tgtWay;
                        state                  <= sAck;
                    end else if (req && hit) begin
                        lru[idx] <= ~hitWay;
                        state    <= sAck;
                    end else if (req) begin
                        state <= victimDirty ? sWriteback : sFill;
                    end
                end
                sWriteback: begin
                    if (memAck) begin
                        dirtyBits[idx][victim] <= 1'b0;
                        state                  <= sMemDrop;
                    end
                end
                sFill: begin
                    if (memAck) begin
                        validBits[idx][victim] <= 1'b1;
                        dirtyBits[idx][victim] <= 1'b0;
                        state                  <= sMemDrop;
                    end
                end
                // back to idle, where the request is looked up again.
                sMemDrop: begin
                    if (!memAck) begin
                        state <= sIdle;
                    end
                end
                default: begin
                    if (!req) begin
                        state <= sIdle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (storeNow) begin
            dataArr[tgtWay][idx] <= wData;
            tagArr[tgtWay][idx]  <= tag;
        end else if (state == sFill && memAck) begin
            dataArr[victim][idx] <= memRData;
            tagArr[victim][idx]  <= tag;
        end
        if (state == sIdle && req && hit && !write) begin
            rData <= dataArr[hitWay][idx];
        end
    end

endmodule

/* design/l1Cache.sv */
`timescale 1ns/1ps
`include "memstage_params.svh"

module l1Cache (
    input  logic                   clk,
    input  logic                   rstN,
    input  memStagePkg::resultSrcT resultSrc,
    input  logic                   memWrite,
    input  logic [31:0]            addr,
    input  logic [31:0]            wData,
    input  logic [2:0]             funct3,
    output logic [31:0]            readData,
    output logic                   stall,
    output logic                   l2Req,
    output logic                   l2Write,
    output logic [31:0]            l2Addr,
    output logic [31:0]            l2WData,
    input  logic                   l2Ack,
    input  logic [31:0]            l2RData
);
    import memStagePkg::*;

    localparam logic [1:0] sIdle      = 2'd0;
    localparam logic [1:0] sWriteback = 2'd1;
    localparam logic [1:0] sFill      = 2'd2;
    localparam logic [1:0] sDropAck   = 2'd3;

    memAddrU             addrU;
    logic [l1IndexW-1:0] idx;
    logic [l1TagW-1:0]   tag;
    logic [offsetW-1:0]  offset;
    accessSizeT          size;

    logic [l1TagW-1:0] tagArr  [2][`L1_SETS];
    logic [31:0]       dataArr [2][`L1_SETS];
    logic [1:0]        validBits [`L1_SETS];
    logic [1:0]        dirtyBits [`L1_SETS];
    logic [`L1_SETS-1:0] lru;

    logic        isLoad;
    logic        access;
    logic [1:0]  wayHit;
    logic        hit;
    logic        hitWay;
    logic        victim;
    logic        victimDirty;
    logic [31:0] lineData;
    logic [31:0] storeWord;
    logic [7:0]  byteLane;
    logic [15:0] halfLane;
    logic [1:0]  state;

    ////////////////////////////////////////
    // lookup
    ////////////////////////////////////////

    assign addrU.word = addr;
    assign idx        = addrU.l1View.index;
    assign tag        = addrU.l1View.tag;
    assign offset     = addrU.l1View.offset;
    assign size       = accessSizeT'(funct3[1:0]);

    assign isLoad = (resultSrc == memResult);
    assign access = isLoad || memWrite;

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            wayHit[w] = validBits[idx][w] && (tagArr[w][idx] == tag);
        end
    end

    assign hit      = |wayHit;
    assign hitWay   = wayHit[1];
    assign lineData = dataArr[hitWay][idx];
    assign stall    = access && !hit;

    // an empty way is used before the lru way is evicted.
    assign victim      = !validBits[idx][0] ? 1'b0 :
                         !validBits[idx][1] ? 1'b1 : lru[idx];
    assign victimDirty = validBits[idx][victim] && dirtyBits[idx][victim];

    ////////////////////////////////////////
    // lane alignment
    ////////////////////////////////////////

    assign byteLane = lineData[{offset, 3'b000} +: 8];
    assign halfLane = lineData[{offset[1], 4'b0000} +: 16];

    always_comb begin
        case (size)
            sizeByte: readData = funct3[2] ? {24'b0, byteLane} : {{24{byteLane[7]}}, byteLane};
            sizeHalf: readData = funct3[2] ? {16'b0, halfLane} : {{16{halfLane[15]}}, halfLane};
            default:  readData = lineData;
        endcase
    end

    always_comb begin
        storeWord = lineData;
        case (size)
            sizeByte: storeWord[{offset, 3'b000} +: 8] = wData[7:0];
            sizeHalf: storeWord[{offset[1], 4'b0000} +: 16] = wData[15:0];
            default:  storeWord = wData;
        endcase
    end

    ////////////////////////////////////////
    // miss handling
    ////////////////////////////////////////

    assign l2Req   = (state == sWriteback) || (state == sFill);
    assign l2Write = (state == sWriteback);
    assign l2Addr  = l2Write ? {tagArr[victim][idx], idx, 2'b00} : {addr[31:2], 2'b00};
    assign l2WData = dataArr[victim][idx];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= sIdle;
            lru   <= '0;
            for (int s = 0; s < `L1_SETS; s++) begin
                validBits[s] <= 2'b00;
                dirtyBits[s] <= 2'b00;
            end
        end else begin
            // hits also complete while the fill ack is still dropping.
            if (access && hit) begin
                lru[idx] <= ~hitWay;
                if (memWrite) begin
                    dirtyBits[idx][hitWay] <= 1'b1;
                end
            end
            case (state)
                sIdle: begin
                    if (access && !hit) begin
                        state <= victimDirty ? sWriteback : sFill;
                    end
                end
                sWriteback: begin
                    if (l2Ack) begin
                        dirtyBits[idx][victim] <= 1'b0;
                        state                  <= sDropAck;
                    end
                end
                sFill: begin
                    if (l2Ack) begin
                        validBits[idx][victim] <= 1'b1;
                        dirtyBits[idx][victim] <= 1'b0;
                        state                  <= sDropAck;
                    end
                end
                default: begin
                    if (!l2Ack) begin
                        state <= sIdle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (access && hit && memWrite) begin
            dataArr[hitWay][idx] <= storeWord;
        end else if (state == sFill && l2Ack) begin
            dataArr[victim][idx] <= l2RData;
            tagArr[victim][idx]  <= tag;
        end
    end

endmodule

/* design/memWbReg.sv */
`timescale 1ns/1ps

module memWbReg (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   stall,
    input  logic                   regWriteM,
    input  memStagePkg::resultSrcT resultSrcM,
    input  logic [31:0]            aluOutM,
    input  logic [31:0]            readDataM,
    input  logic [4:0]             rdM,
    input  logic [31:0]            incPcM,
    output logic                   regWriteW,
    output memStagePkg::resultSrcT resultSrcW,
    output logic [31:0]            aluOutW,
    output logic [31:0]            readDataW,
    output logic [4:0]             rdW,
    output logic [31:0]            incPcW
);
    import memStagePkg::*;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regWriteW  <= 1'b0;
            resultSrcW <= aluResult;
        end else if (stall) begin
            // writeback sees a bubble.
            regWriteW <= 1'b0;
        end else begin
            regWriteW  <= regWriteM;
            resultSrcW <= resultSrcM;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            aluOutW   <= aluOutM;
            readDataW <= readDataM;
            rdW       <= rdM;
            incPcW    <= incPcM;
        end
    end

endmodule

/* design/mainMemory.sv */
`timescale 1ns/1ps
`include "memstage_params.svh"

module mainMemory (
    input  logic        clk,
    input  logic        rstN,
    input  logic        req,
    input  logic        write,
    input  logic [31:0] addr,
    input  logic [31:0] wData,
    output logic        ack,
    output logic [31:0] rData
);

    localparam int wordIdxW = $clog2(`MEM_WORDS);
    localparam int cntW     = $clog2(`MEM_LATENCY) + 1;

    logic [31:0]         mem [`MEM_WORDS];
    logic [cntW-1:0]     count;
    logic [wordIdxW-1:0] wordIdx;

    assign wordIdx = addr[wordIdxW+1:2];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ack   <= 1'b0;
            count <= '0;
            rData <= '0;
            for (int i = 0; i < `MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (req && !ack) begin
            if (count == cntW'(`MEM_LATENCY - 1)) begin
                count <= '0;
                ack   <= 1'b1;
                if (write) begin
                    mem[wordIdx] <= wData;
                end else begin
                    rData <= mem[wordIdx];
                end
            end else begin
                count <= count + 1'b1;
            end
        end else if (ack && !req) begin
            // requester has taken the data.
            ack <= 1'b0;
        end
    end

endmodule

/* design/memStagePkg.sv */
`include "memstage_params.svh"

package memStagePkg;

    localparam int offsetW  = 2;
    localparam int l1IndexW = $clog2(`L1_SETS);
    localparam int l2IndexW = $clog2(`L2_SETS);
    localparam int l1TagW   = 32 - l1IndexW - offsetW;
    localparam int l2TagW   = 32 - l2IndexW - offsetW;

    // writeback mux select, memResult marks a load.
    typedef enum logic [1:0] {
        aluResult = 2'b00,
        memResult = 2'b01,
        pcPlus4   = 2'b10
    } resultSrcT;

    // low two bits of funct3, bit 2 selects an unsigned load.
    typedef enum logic [1:0] {
        sizeByte = 2'b00,
        sizeHalf = 2'b01,
        sizeWord = 2'b10
    } accessSizeT;

    // one address word, split differently by each cache level.
    typedef union packed {
        logic [31:0] word;
        struct packed {
            logic [l1TagW-1:0]   tag;
            logic [l1IndexW-1:0] index;
            logic [offsetW-1:0]  offset;
        } l1View;
        struct packed {
            logic [l2TagW-1:0]   tag;
            logic [l2IndexW-1:0] index;
            logic [offsetW-1:0]  offset;
        } l2View;
    } memAddrU;

endpackage

/* include/memstage_params.svh */
`ifndef MEMSTAGE_PARAMS_SVH
`define MEMSTAGE_PARAMS_SVH

////////////////////////////////////////
// cache geometry
////////////////////////////////////////

// sets per level, two ways each and one word per line.
`define L1_SETS 4
`define L2_SETS 16

////////////////////////////////////////
// backing store
////////////////////////////////////////

// depth in 32-bit words.
`define MEM_WORDS 1024

// cycles from req to ack.
`define MEM_LATENCY 4

`endif
